//--- bench/afe_tests.svh
`ifndef AFE_TESTS_SVH
`define AFE_TESTS_SVH

  ////////////////////////////////////////
  // Reset and acquisition
  ////////////////////////////////////////

  // Outputs quiet in reset and on the first clean cycle
  task automatic test_reset();
    for (int cyc = 0; cyc < 4; cyc++) begin
      @(negedge adc_clk);
      for (int c = 0; c < CHN; c++) begin
        chk_cnt++;
        if (acq_valid_o[c] !== 1'b0) begin
          report_mismatch($sformatf("acq_valid_o[%0d]", c), acq_valid_o[c], 0);
        end
        check_dac(c, DAC_IDLE);
      end
      // Three reset cycles
      if (cyc == 2) begin
        top_rst = 1'b0;
      end
    end
  endtask

  // Unity gain with a new raw word each cycle
  task automatic test_adc_unity();
    code_t raw_hist [CHN][64];
    for (int k = 0; k < 64 + 3; k++) begin
      @(negedge adc_clk);
      for (int c = 0; c < CHN; c++) begin
        // Word driven three cycles back
        if (k >= 3) begin
          check_acq(c, adc_model(raw_hist[c][k-3]));
        end
        adc_cal_i[c].mul = 16'sd16384;
        adc_cal_i[c].sum = '0;
        mux_loop_i[c]    = 1'b0;
        acq_ready_i[c]   = 1'b1;
        if (k < 64) begin
          raw_hist[c][k] = code_t'(rand_bits(SMP_W));
          adc_dat_i[c]   = raw_hist[c][k];
        end
      end
    end
  endtask

  // Random gain and offset over the full range
  task automatic test_calib();
    smp_t        want;
    int unsigned hit_max;
    int unsigned hit_min;
    hit_max = 0;
    hit_min = 0;
    for (int n = 0; n < 80; n++) begin
      @(negedge adc_clk);
      for (int c = 0; c < CHN; c++) begin
        adc_cal_i[c].mul = CAL_MUL_W'(rand_bits(CAL_MUL_W));
        adc_cal_i[c].sum = smp_t'(rand_bits(SMP_W));
        adc_dat_i[c]     = code_t'(rand_bits(SMP_W));
        // First two rounds drive full scale at almost double gain
        if (n < 2) begin
          adc_cal_i[c].mul = 16'sd32767;
          adc_cal_i[c].sum = '0;
          adc_dat_i[c]     = (n == 0) ? 14'h0000 : 14'h3FFF;
        end
      end
      repeat (3) @(negedge adc_clk);
      for (int c = 0; c < CHN; c++) begin
        want = cal_model(adc_cal_i[c], adc_model(adc_dat_i[c]));
        check_acq(c, want);
        // Limits as seen on the DUT output
        hit_max += (acq_o[c] === SMP_MAX);
        hit_min += (acq_o[c] === SMP_MIN);
      end
    end
    if (hit_max == 0 || hit_min == 0) begin
      $display("ERROR: acq_o did not reach both saturation limits");
      err_cnt++;
    end
  endtask

  // Random stalls on a constant ADC word
  task automatic test_backpressure();
    smp_t           want [CHN];
    smp_t           held [CHN];
    logic [CHN-1:0] stalled;
    @(negedge adc_clk);
    for (int c = 0; c < CHN; c++) begin
      adc_cal_i[c].mul = CAL_MUL_W'(rand_bits(CAL_MUL_W));
      adc_cal_i[c].sum = smp_t'(rand_bits(SMP_W));
      adc_dat_i[c]     = code_t'(rand_bits(SMP_W));
      want[c] = cal_model(adc_cal_i[c], adc_model(adc_dat_i[c]));
    end
    // Let the pipe fill with the new word
    repeat (4) @(negedge adc_clk);
    for (int k = 0; k < 100; k++) begin
      for (int c = 0; c < CHN; c++) begin
        acq_ready_i[c] = (rand_bits(1) != 0);
        stalled[c]     = acq_valid_o[c] & ~acq_ready_i[c];
        held[c]        = acq_o[c];
        // Beat taken on the coming edge
        if (acq_valid_o[c] & acq_ready_i[c]) begin
          check_acq(c, want[c]);
        end
      end
      @(negedge adc_clk);
      for (int c = 0; c < CHN; c++) begin
        if (stalled[c]) begin
          check_acq(c, held[c]);
        end
      end
    end
    acq_ready_i = '1;
  endtask

  ////////////////////////////////////////
  // Generation and loopback
  ////////////////////////////////////////

  // Generator beats with gaps while the DAC holds in between
  task automatic test_generation();
    smp_t  dat_hist [CHN][64];
    logic  vld_hist [CHN][64];
    code_t want [CHN];
    @(negedge adc_clk);
    for (int c = 0; c < CHN; c++) begin
      dac_cal_i[c].mul = CAL_MUL_W'(rand_bits(CAL_MUL_W));
      dac_cal_i[c].sum = smp_t'(rand_bits(SMP_W));
      want[c] = DAC_IDLE;
    end
    for (int k = 0; k < 60 + 3; k++) begin
      @(negedge adc_clk);
      for (int c = 0; c < CHN; c++) begin
        if (k >= 3 && vld_hist[c][k-3]) begin
          want[c] = dac_model(cal_model(dac_cal_i[c], dat_hist[c][k-3]));
        end
        check_dac(c, want[c]);
        if (gen_ready_o[c] !== 1'b1) begin
          report_mismatch($sformatf("gen_ready_o[%0d]", c), gen_ready_o[c], 1);
        end
        if (k < 60) begin
          // New beat only once the last one is taken
          if (!gen_valid_i[c] || gen_ready_o[c]) begin
            gen_valid_i[c] = (rand_bits(2) != 0);
            gen_i[c]       = smp_t'(rand_bits(SMP_W));
          end
          vld_hist[c][k] = gen_valid_i[c] & gen_ready_o[c];
          dat_hist[c][k] = gen_i[c];
        end else begin
          gen_valid_i[c] = 1'b0;
        end
      end
    end
  endtask

  // Each channel in turn reads back its own DAC
  task automatic test_loopback();
    smp_t        gen_want;
    code_t       code_want;
    int unsigned waited;
    for (int lc = 0; lc < CHN; lc++) begin
      @(negedge adc_clk);
      for (int c = 0; c < CHN; c++) begin
        adc_cal_i[c].mul = CAL_MUL_W'(rand_bits(CAL_MUL_W));
        adc_cal_i[c].sum = smp_t'(rand_bits(SMP_W));
        adc_dat_i[c]     = code_t'(rand_bits(SMP_W));
        mux_loop_i[c]    = (c == lc);
      end
      gen_i[lc]       = smp_t'(rand_bits(SMP_W));
      gen_valid_i[lc] = 1'b1;
      gen_want  = cal_model(dac_cal_i[lc], gen_i[lc]);
      code_want = dac_model(gen_want);
      @(negedge adc_clk);
      gen_valid_i[lc] = 1'b0;
      waited = 0;
      while (dac_dat_o[lc] !== code_want && waited < 10) begin
        @(negedge adc_clk);
        waited++;
      end
      if (dac_dat_o[lc] !== code_want) begin
        $display("Timeout: dac_dat_o[%0d] never took the generator beat", lc);
        tmo_cnt++;
        finish_run();
      end
      // Through the ADC register and both calib stages
      repeat (3) @(negedge adc_clk);
      for (int c = 0; c < CHN; c++) begin
        if (c == lc) begin
          check_acq(c, cal_model(adc_cal_i[c], gen_want));
        end else begin
          check_acq(c, cal_model(adc_cal_i[c], adc_model(adc_dat_i[c])));
        end
      end
    end
    mux_loop_i = '0;
  endtask

`endif

//--- bench/afe_tb.sv
module afe_tb import afe_pkg::*; ();

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  localparam int unsigned CHN = 2;

  // Raw ADC or DAC code word
  typedef logic [SMP_W-1:0] code_t;

  logic               adc_clk;
  logic               top_rst;
  code_t [CHN-1:0]    adc_dat_i;
  logic [CHN-1:0]     mux_loop_i;
  cal_cfg_t [CHN-1:0] adc_cal_i;
  cal_cfg_t [CHN-1:0] dac_cal_i;
  smp_t [CHN-1:0]     gen_i;
  logic [CHN-1:0]     gen_valid_i;
  logic [CHN-1:0]     gen_ready_o;
  smp_t [CHN-1:0]     acq_o;
  logic [CHN-1:0]     acq_valid_o;
  logic [CHN-1:0]     acq_ready_i;
  code_t [CHN-1:0]    dac_dat_o;

  // Run bookkeeping
  int unsigned chk_cnt;
  int unsigned err_cnt;
  int unsigned tmo_cnt;
  logic [31:0] lfsr_q;

  afe_top #(
    .CHN (CHN)
  ) DUT (
    .*
  );

  // Free running clock, period 100
  initial begin
    adc_clk = 1'b0;
    forever begin
      #50 adc_clk = ~adc_clk;
    end
  end

  ////////////////////////////////////////
  // Random source and models
  ////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  // one step per returned bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // Inverted offset binary, top bit kept
  function automatic smp_t adc_model(input code_t raw);
    return smp_t'(raw ^ code_t'(14'h1FFF));
  endfunction

  // Gain with floor shift, then offset, then clip
  function automatic smp_t cal_model(input cal_cfg_t cfg, input smp_t x);
    longint acc;
    acc = longint'(x) * longint'(cfg.mul);
    acc = (acc >>> CAL_FRAC) + longint'(cfg.sum);
    if (acc > longint'(SMP_MAX)) begin
      acc = longint'(SMP_MAX);
    end else if (acc < longint'(SMP_MIN)) begin
      acc = longint'(SMP_MIN);
    end
    return smp_t'(acc);
  endfunction

  // Sign kept, magnitude flipped, unsigned code
  function automatic code_t dac_model(input smp_t x);
    return code_t'(x) ^ code_t'(14'h1FFF);
  endfunction

  ////////////////////////////////////////
  // Checks and end of run
  ////////////////////////////////////////

  task automatic report_mismatch(input string name, input longint got, input longint want);
    $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, want);
    err_cnt++;
  endtask

  // Acquisition beat present and correct
  task automatic check_acq(input int c, input smp_t want);
    chk_cnt++;
    if (acq_valid_o[c] !== 1'b1) begin
      report_mismatch($sformatf("acq_valid_o[%0d]", c), acq_valid_o[c], 1);
    end
    if (acq_o[c] !== want) begin
      report_mismatch($sformatf("acq_o[%0d]", c), acq_o[c], want);
    end
  endtask

  task automatic check_dac(input int c, input code_t want);
    chk_cnt++;
    if (dac_dat_o[c] !== want) begin
      report_mismatch($sformatf("dac_dat_o[%0d]", c), dac_dat_o[c], want);
    end
  endtask

  task automatic finish_run();
    $display("Checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  `include "afe_tests.svh"

  // Test sequence
  initial begin
    lfsr_q      = 32'h653d_e90e;
    chk_cnt     = 0;
    err_cnt     = 0;
    tmo_cnt     = 0;
    top_rst     = 1'b1;
    adc_dat_i   = '0;
    mux_loop_i  = '0;
    adc_cal_i   = '0;
    dac_cal_i   = '0;
    gen_i       = '0;
    gen_valid_i = '0;
    acq_ready_i = '0;
    test_reset();
    test_adc_unity();
    test_calib();
    test_backpressure();
    test_generation();
    test_loopback();
    finish_run();
  end

endmodule : afe_tb

//--- design/adc_input_stage.sv
module adc_input_stage import afe_pkg::*; (
  // Clock and reset
  input  logic             adc_clk,
  input  logic             top_rst,
  // Raw ADC word, reserved low bits already stripped
  input  logic [SMP_W-1:0] adc_raw_i,
  // Loopback select
  input  logic             loop_i,
  // Sample held by the DAC of this channel
  input  smp_t             dac_smp_i,
  // Registered sample stream
  output smp_t             smp_o,
  output logic             valid_o
);

  // Converted ADC word
  smp_t adc_smp;

  // Inverted offset binary to two's complement
  // sign bit kept, magnitude bits flipped
  always_comb begin
    adc_smp = {adc_raw_i[SMP_W-1], ~adc_raw_i[SMP_W-2:0]};
  end

  // Input register
  // ADC word or looped DAC sample
  always_ff @(posedge adc_clk) begin
    if (loop_i) begin
      smp_o <= dac_smp_i;
    end else begin
      smp_o <= adc_smp;
    end
  end

  // ADC runs free
  // a new sample every cycle once out of reset
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= 1'b1;
    end
  end

  // Loopback select must be driven
  // an X here would poison the whole acquisition chain
  a_loop_known : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$isunknown(loop_i)
  ) else $error("loopback select unknown");

endmodule : adc_input_stage

//--- design/afe_pkg.sv
package afe_pkg;

  ////////////////////////////////////////
  // Sample streams
  ////////////////////////////////////////

  // Sample width in every stream
  localparam int unsigned SMP_W = 14;

  // One signed sample word
  typedef logic signed [SMP_W-1:0] smp_t;

  // Saturation limits of a sample
  localparam smp_t SMP_MAX = smp_t'((1 << (SMP_W - 1)) - 1);
  localparam smp_t SMP_MIN = smp_t'(-(1 << (SMP_W - 1)));

  ////////////////////////////////////////
  // Calibration
  ////////////////////////////////////////

  // Gain factor width
  localparam int unsigned CAL_MUL_W = 16;

  // Fraction bits of the gain
  // unity gain is 1 << CAL_FRAC
  localparam int unsigned CAL_FRAC = 14;

  // One calibration setting, gain above offset
  typedef struct packed {
    // Gain, signed fixed point
    logic signed [CAL_MUL_W-1:0] mul;
    // Offset in sample units
    smp_t                        sum;
  } cal_cfg_t;

  ////////////////////////////////////////
  // DAC
  ////////////////////////////////////////

  // DAC code of a zero sample
  // mid scale on the inverted slope
  localparam logic [SMP_W-1:0] DAC_IDLE = 14'h1FFF;

endpackage : afe_pkg

//--- design/afe_top.sv
module afe_top import afe_pkg::*; #(
  // Number of channels
  parameter int unsigned CHN = 2
) (
  // Clock and reset
  input  logic                        adc_clk,
  input  logic                        top_rst,
  // ADC words, reserved low bits dropped
  input  logic [CHN-1:0][SMP_W-1:0]   adc_dat_i,
  // Per channel loopback of the DAC sample
  input  logic [CHN-1:0]              mux_loop_i,
  // Calibration settings
  input  cal_cfg_t [CHN-1:0]          adc_cal_i,
  input  cal_cfg_t [CHN-1:0]          dac_cal_i,
  // Generator streams
  input  smp_t [CHN-1:0]              gen_i,
  input  logic [CHN-1:0]              gen_valid_i,
  output logic [CHN-1:0]              gen_ready_o,
  // Acquisition streams
  output smp_t [CHN-1:0]              acq_o,
  output logic [CHN-1:0]              acq_valid_o,
  input  logic [CHN-1:0]              acq_ready_i,
  // DAC words, one per channel
  output logic [CHN-1:0][SMP_W-1:0]   dac_dat_o
);

  ////////////////////////////////////////
  // Per channel pipelines
  ////////////////////////////////////////

  generate
    for (genvar i = 0; i < CHN; i++) begin : for_chn

      // Registered ADC stream
      smp_t adc_smp;
      logic adc_vld;
      // Calibrated generator stream
      smp_t gen_smp;
      logic gen_vld;
      // DAC sample fed back for loopback
      smp_t dac_smp;

      // ADC register, conversion, loopback mux
      adc_input_stage adc_in (
        .adc_clk   (adc_clk),
        .top_rst   (top_rst),
        .adc_raw_i (adc_dat_i[i]),
        .loop_i    (mux_loop_i[i]),
        .dac_smp_i (dac_smp),
        .smp_o     (adc_smp),
        .valid_o   (adc_vld)
      );

      // Acquisition calibration
      // ADC cannot stall so a sample met by low ready is lost
      linear_calib #(
        .FRAC_BITS (CAL_FRAC)
      ) calib_adc (
        .adc_clk     (adc_clk),
        .top_rst     (top_rst),
        .cfg_i       (adc_cal_i[i]),
        .in_i        (adc_smp),
        .in_valid_i  (adc_vld),
        .in_ready_o  (),
        .out_o       (acq_o[i]),
        .out_valid_o (acq_valid_o[i]),
        .out_ready_i (acq_ready_i[i])
      );

      // Generation calibration
      // DAC stage takes every beat, so ready is tied high
      linear_calib #(
        .FRAC_BITS (CAL_FRAC)
      ) calib_dac (
        .adc_clk     (adc_clk),
        .top_rst     (top_rst),
        .cfg_i       (dac_cal_i[i]),
        .in_i        (gen_i[i]),
        .in_valid_i  (gen_valid_i[i]),
        .in_ready_o  (gen_ready_o[i]),
        .out_o       (gen_smp),
        .out_valid_o (gen_vld),
        .out_ready_i (1'b1)
      );

      // DAC code and output register
      dac_output_stage dac_out (
        .adc_clk    (adc_clk),
        .top_rst    (top_rst),
        .in_i       (gen_smp),
        .in_valid_i (gen_vld),
        .dac_smp_o  (dac_smp),
        .dac_dat_o  (dac_dat_o[i])
      );

    end : for_chn
  endgenerate

endmodule : afe_top

//--- design/dac_output_stage.sv
module dac_output_stage import afe_pkg::*; (
  // Clock and reset
  input  logic             adc_clk,
  input  logic             top_rst,
  // Calibrated generator stream, always accepted
  input  smp_t             in_i,
  input  logic             in_valid_i,
  // Signed sample for loopback
  output smp_t             dac_smp_o,
  // DAC code toward the converter
  output logic [SMP_W-1:0] dac_dat_o
);

  // Converted code of the incoming sample
  logic [SMP_W-1:0] dac_code;

  // Two's complement to offset binary on a negative slope
  // sign kept, magnitude bits flipped
  always_comb begin
    dac_code = {in_i[SMP_W-1], ~in_i[SMP_W-2:0]};
  end

  // Output register
  // holds the last code between beats
  // idles at mid scale
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= DAC_IDLE;
    end else if (in_valid_i) begin
      dac_dat_o <= dac_code;
    end
  end

  // Same mapping undone
  // zero after reset since the code idles at mid scale
  always_comb begin
    dac_smp_o = {dac_dat_o[SMP_W-1], ~dac_dat_o[SMP_W-2:0]};
  end

endmodule : dac_output_stage

//--- design/linear_calib.sv
module linear_calib import afe_pkg::*; #(
  // Fraction bits of the gain
  parameter int unsigned FRAC_BITS = 14
) (
  // Clock and reset
  input  logic     adc_clk,
  input  logic     top_rst,
  // Calibration setting
  input  cal_cfg_t cfg_i,
  // Input stream
  input  smp_t     in_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  // Output stream
  output smp_t     out_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  ////////////////////////////////////////
  // Local widths and signals
  ////////////////////////////////////////

  // Full product
  localparam int unsigned PRD_W = SMP_W + CAL_MUL_W;
  // Product after the fraction shift
  localparam int unsigned SFT_W = PRD_W - FRAC_BITS;
  // Offset sum, one guard bit
  localparam int unsigned ADD_W = SFT_W + 1;

  // Whole pipe moves together
  logic pipe_en;

  // Stage one, product
  logic                    s1_vld;
  logic signed [PRD_W-1:0] s1_prd;

  // Stage two arithmetic
  logic signed [SFT_W-1:0] prd_sft;
  logic signed [ADD_W-1:0] prd_add;
  smp_t                    prd_sat;

  // Stage two, result
  logic s2_vld;
  smp_t s2_dat;

  ////////////////////////////////////////
  // Flow control
  ////////////////////////////////////////

  // Advance when the last stage is empty or drains now
  // a stalled output freezes both stages
  assign pipe_en = ~s2_vld | out_ready_i;
  assign in_ready_o = pipe_en;

  ////////////////////////////////////////
  // Stage one
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      s1_vld <= 1'b0;
    end else if (pipe_en) begin
      s1_vld <= in_valid_i;
    end
  end

  // Signed gain multiply
  always_ff @(posedge adc_clk) begin
    if (pipe_en & in_valid_i) begin
      s1_prd <= PRD_W'(in_i) * PRD_W'(cfg_i.mul);
    end
  end

  ////////////////////////////////////////
  // Stage two
  ////////////////////////////////////////

  always_comb begin
    // Arithmetic shift floors toward minus infinity
    prd_sft = SFT_W'(s1_prd >>> FRAC_BITS);
    // Offset
    prd_add = ADD_W'(prd_sft) + ADD_W'(cfg_i.sum);
    // Clip to sample range
    if (prd_add > ADD_W'(SMP_MAX)) begin
      prd_sat = SMP_MAX;
    end else if (prd_add < ADD_W'(SMP_MIN)) begin
      prd_sat = SMP_MIN;
    end else begin
      prd_sat = prd_add[SMP_W-1:0];
    end
  end

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      s2_vld <= 1'b0;
    end else if (pipe_en) begin
      s2_vld <= s1_vld;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (pipe_en & s1_vld) begin
      s2_dat <= prd_sat;
    end
  end

  // Output stream
  assign out_o       = s2_dat;
  assign out_valid_o = s2_vld;

  // Stream rule on the output side
  // a pending beat is neither withdrawn nor changed
  a_out_hold_valid : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    out_valid_o && !out_ready_i |=> out_valid_o
  ) else $error("output valid dropped while stalled");

  a_out_hold_data : assert property (
    @(posedge adc_clk) disable iff (top_rst)
    out_valid_o && !out_ready_i |=> $stable(out_o)
  ) else $error("output data changed while stalled");

endmodule : linear_calib

//--- run_sim.sh
#!/bin/sh
# Build the AFE testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module afe_tb -o afe_sim \
  && ./obj_dir/afe_sim > sim.log 2>&1 \
  || { echo "Build or simulation error"; exit 1; }
cat sim.log
if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0

//--- verilog.f
+incdir+bench
design/afe_pkg.sv
design/adc_input_stage.sv
design/linear_calib.sv
design/dac_output_stage.sv
design/afe_top.sv
bench/afe_tb.sv
